// ==== Bender.yml ====
package:
  name: lc3b_pipeline

sources:
  - source/lc3b_types.sv
  - source/instruction_fetch.sv
  - source/instruction_decode.sv
  - source/execution_module.sv
  - source/memory_module.sv
  - source/writeback_module.sv
  - source/cpu_datapath.sv
  - target: test
    files:
      - dv/cpu_datapath_tb.sv

// ==== dv/cpu_datapath_tb.sv ====
`timescale 1ns/10ps

module cpu_datapath_tb;
	import lc3b_types::*;

	localparam int imem_words = 512;
	localparam int dmem_words = 256;
	localparam int slots      = 32;

	logic        clk;
	logic        reset;
	lc3b_word    mem_addr1;
	logic        mem_read1;
	lc3b_word    mem_rdata1;
	lc3b_word    mem_addr2;
	logic        mem_read2;
	logic        mem_write2;
	lc3b_word    mem_rdata2;
	lc3b_word    mem_wdata2;

	lc3b_word    imem [imem_words];
	lc3b_word    dmem [dmem_words];
	lc3b_word    ref_regs [8];
	lc3b_word    ref_dmem [dmem_words];
	lc3b_word    exp_addr [$];
	lc3b_word    exp_data [$];
	lc3b_word    exp_pc [$];
	lc3b_word    addr_hist [3];
	logic [15:0] lfsr_state;
	int          prog_words;
	int          cycle_limit;
	int          cycle_count;
	int          early_cycles;
	logic        checking;
	lc3b_word    fetch_expect;

	cpu_datapath u_dut (
		.clk        (clk),
		.reset      (reset),
		.mem_addr1  (mem_addr1),
		.mem_read1  (mem_read1),
		.mem_rdata1 (mem_rdata1),
		.mem_addr2  (mem_addr2),
		.mem_read2  (mem_read2),
		.mem_write2 (mem_write2),
		.mem_rdata2 (mem_rdata2),
		.mem_wdata2 (mem_wdata2)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// memory model
	// ==============================

	assign mem_rdata1 = imem[mem_addr1[9:1]];
	assign mem_rdata2 = dmem[mem_addr2[8:1]];

	always @(posedge clk) begin
		if (mem_write2) begin
			dmem[mem_addr2[8:1]] <= mem_wdata2;
		end
	end

	// ==============================
	// stimulus and reference
	// ==============================

	// galois form, taps 16, 14, 13, 11.
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 16'hb400;
		end
		return out;
	endfunction

	function automatic lc3b_word random_bits(input int n);
		lc3b_word v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_bit()};
		end
		return v;
	endfunction

	// R7 holds the load/store base, so it is never a destination.
	function automatic lc3b_reg pick_dest();
		lc3b_reg r;
		r = 3'(random_bits(3));
		if (r == 3'd7) begin
			r = 3'd0;
		end
		return r;
	endfunction

	// one instruction on the model state, by the ISA rules.
	function automatic void ref_step(input lc3b_word instr, input lc3b_word addr);
		lc3b_word b;
		lc3b_word ea;
		if (instr[5]) begin
			b = {{11{instr[4]}}, instr[4:0]};
		end else begin
			b = ref_regs[instr[2:0]];
		end
		ea = ref_regs[instr[8:6]] + {{9{instr[5]}}, instr[5:0], 1'b0};
		case (instr[15:12])
			op_add: ref_regs[instr[11:9]] = ref_regs[instr[8:6]] + b;
			op_and: ref_regs[instr[11:9]] = ref_regs[instr[8:6]] & b;
			op_not: ref_regs[instr[11:9]] = ~ref_regs[instr[8:6]];
			op_ldr: ref_regs[instr[11:9]] = ref_dmem[ea[8:1]];
			op_str: begin
				ref_dmem[ea[8:1]] = ref_regs[instr[11:9]];
				exp_addr.push_back(ea);
				exp_data.push_back(ref_regs[instr[11:9]]);
				exp_pc.push_back(addr);
			end
			default: ;
		endcase
	endfunction

	// the three words after each instruction stay zero, which are no-ops.
	task automatic emit(input lc3b_word instr);
		imem[prog_words] = instr;
		ref_step(instr, lc3b_word'(prog_words * 2));
		prog_words = prog_words + 4;
	endtask

	task automatic build_program();
		lc3b_reg    dr;
		lc3b_reg    sa;
		lc3b_reg    sb;
		logic [5:0] off;
		logic [2:0] kind;
		lfsr_state = 16'd14;
		prog_words = 0;
		for (int i = 0; i < imem_words; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i] = random_bits(16);
			ref_dmem[i] = dmem[i];
		end
		for (int i = 0; i < 8; i++) begin
			ref_regs[i] = '0;
		end
		// base R7 = 8 doubled four times.
		emit({op_and, 3'd7, 3'd7, 1'b1, 5'd0});
		emit({op_add, 3'd7, 3'd7, 1'b1, 5'd8});
		repeat (4) begin
			emit({op_add, 3'd7, 3'd7, 3'b000, 3'd7});
		end
		// a load and store below the base.
		emit({op_ldr, 3'd1, 3'd7, 6'b110000});
		emit({op_str, 3'd1, 3'd7, 6'b110000});
		for (int i = 0; i < slots; i++) begin
			kind = 3'(random_bits(3));
			dr = pick_dest();
			sa = 3'(random_bits(3));
			sb = 3'(random_bits(3));
			off = 6'(random_bits(6));
			case (kind)
				3'd0: emit({op_add, dr, sa, 3'b000, sb});
				3'd1: emit({op_add, dr, sa, 1'b1, off[4:0]});
				3'd2: emit({op_and, dr, sa, 3'b000, sb});
				3'd3: emit({op_and, dr, sa, 1'b1, off[4:0]});
				3'd4: emit({op_not, dr, sa, 6'b111111});
				3'd7: emit({op_str, sa, 3'd7, off});
				default: begin
					emit({op_ldr, dr, 3'd7, off});
					emit({op_str, dr, 3'd7, off});
				end
			endcase
		end
		// dump every register so the checker sees it.
		for (int r = 0; r < 8; r++) begin
			emit({op_str, 3'(r), 3'd7, 6'(r)});
		end
		cycle_limit = 4 * prog_words + 20;
	endtask

	// ==============================
	// checking
	// ==============================

	task automatic check_value(
		input string    name,
		input lc3b_word expected,
		input lc3b_word actual
	);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// sampled mid-cycle, addr_hist[2] is the fetch address three cycles back.
	always @(negedge clk) begin
		if (checking) begin
			check_value("fetch address", fetch_expect, mem_addr1);
			fetch_expect = fetch_expect + 16'd2;
			// reset drops on the first checked edge.
			if (early_cycles > 0) begin
				check_value("fetch strobe", 16'd1, 16'(mem_read1));
			end
			if (early_cycles < 3) begin
				check_value("read strobe after reset", 16'd0, 16'(mem_read2));
				check_value("write strobe after reset", 16'd0, 16'(mem_write2));
				early_cycles = early_cycles + 1;
			end
			if (mem_write2) begin
				if (exp_addr.size() == 0) begin
					$display("store to %h was not expected by the reference", mem_addr2);
					$display("RESULT: FAIL");
					$fatal(1, "unexpected store");
				end else begin
					check_value("store address", exp_addr.pop_front(), mem_addr2);
					check_value("store data", exp_data.pop_front(), mem_wdata2);
					check_value("store timing", exp_pc.pop_front(), addr_hist[2]);
				end
			end
			addr_hist[2] = addr_hist[1];
			addr_hist[1] = addr_hist[0];
			addr_hist[0] = mem_addr1;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		reset = 1'b1;
		checking = 1'b0;
		early_cycles = 0;
		cycle_count = 0;
		fetch_expect = '0;
		for (int i = 0; i < 3; i++) begin
			addr_hist[i] = '0;
		end
		build_program();
		repeat (3) @(posedge clk);
		check_value("fetch strobe in reset", 16'd0, 16'(mem_read1));
		checking = 1'b1;
		@(negedge clk);
		reset = 1'b0;
		// run until fetch is past the program and the pipe has drained.
		while (mem_addr1 < lc3b_word'(prog_words * 2 + 8)) begin
			@(negedge clk);
		end
		if (exp_addr.size() != 0) begin
			$display("%0d expected stores never appeared on port 2", exp_addr.size());
			$display("RESULT: FAIL");
			$fatal(1, "missing stores");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule : cpu_datapath_tb

// ==== flist.f ====
source/lc3b_types.sv
source/instruction_fetch.sv
source/instruction_decode.sv
source/execution_module.sv
source/memory_module.sv
source/writeback_module.sv
source/cpu_datapath.sv
dv/cpu_datapath_tb.sv

// ==== source/cpu_datapath.sv ====
`timescale 1ns/10ps

module cpu_datapath (
	input  logic                 clk,
	input  logic                 reset,
	output lc3b_types::lc3b_word mem_addr1,
	output logic                 mem_read1,
	input  lc3b_types::lc3b_word mem_rdata1,
	output lc3b_types::lc3b_word mem_addr2,
	output logic                 mem_read2,
	output logic                 mem_write2,
	input  lc3b_types::lc3b_word mem_rdata2,
	output lc3b_types::lc3b_word mem_wdata2
);
	import lc3b_types::*;

	// IF/ID.
	lc3b_word    if_ir;
	lc3b_word    if_pc;
	// ID/EX.
	lc3b_word    id_ir;
	lc3b_word    id_pc;
	lc3b_control id_control;
	lc3b_word    id_sr1;
	lc3b_word    id_sr2;
	// EX/MEM.
	lc3b_word    ex_ir;
	lc3b_control ex_control;
	lc3b_word    ex_alu;
	lc3b_word    ex_store_data;
	// MEM/WB.
	lc3b_word    mem_ir;
	lc3b_control mem_control;
	lc3b_word    mem_alu;
	lc3b_word    mem_mdr;
	// register file write.
	logic        wb_load;
	lc3b_reg     wb_dest;
	lc3b_word    wb_data;

	// fetch port idles while in reset.
	assign mem_read1 = ~reset;

	instruction_fetch u_fetch (
		.clk   (clk),
		.reset (reset),
		.instr (mem_rdata1),
		.pc    (mem_addr1),
		.ir    (if_ir),
		.ir_pc (if_pc)
	);

	instruction_decode u_decode (
		.clk     (clk),
		.reset   (reset),
		.ir_in   (if_ir),
		.pc_in   (if_pc),
		.wb_load (wb_load),
		.wb_dest (wb_dest),
		.wb_data (wb_data),
		.ir      (id_ir),
		.pc      (id_pc),
		.control (id_control),
		.sr1     (id_sr1),
		.sr2     (id_sr2)
	);

	execution_module u_execute (
		.clk        (clk),
		.reset      (reset),
		.ir_in      (id_ir),
		.pc_in      (id_pc),
		.control_in (id_control),
		.sr1        (id_sr1),
		.sr2        (id_sr2),
		.ir         (ex_ir),
		.control    (ex_control),
		.alu        (ex_alu),
		.store_data (ex_store_data)
	);

	memory_module u_memory (
		.clk        (clk),
		.reset      (reset),
		.ir_in      (ex_ir),
		.control_in (ex_control),
		.alu_in     (ex_alu),
		.store_data (ex_store_data),
		.mem_rdata  (mem_rdata2),
		.mem_addr   (mem_addr2),
		.mem_read   (mem_read2),
		.mem_write  (mem_write2),
		.mem_wdata  (mem_wdata2),
		.ir         (mem_ir),
		.control    (mem_control),
		.alu        (mem_alu),
		.mdr        (mem_mdr)
	);

	writeback_module u_writeback (
		.ir_in        (mem_ir),
		.control_in   (mem_control),
		.alu_in       (mem_alu),
		.mdr_in       (mem_mdr),
		.regfile_load (wb_load),
		.dest         (wb_dest),
		.data         (wb_data)
	);

endmodule : cpu_datapath

// ==== source/execution_module.sv ====
`timescale 1ns/10ps

module execution_module (
	input  logic                    clk,
	input  logic                    reset,
	input  lc3b_types::lc3b_word    ir_in,
	input  lc3b_types::lc3b_word    pc_in,
	input  lc3b_types::lc3b_control control_in,
	input  lc3b_types::lc3b_word    sr1,
	input  lc3b_types::lc3b_word    sr2,
	output lc3b_types::lc3b_word    ir,
	output lc3b_types::lc3b_control control,
	output lc3b_types::lc3b_word    alu,
	output lc3b_types::lc3b_word    store_data
);
	import lc3b_types::*;

	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word operand_b;
	lc3b_word addr_sum;
	lc3b_word result;

	assign imm5      = {{11{ir_in[4]}}, ir_in[4:0]};
	// word offset, scaled to bytes.
	assign offset6   = {{9{ir_in[5]}}, ir_in[5:0], 1'b0};
	assign operand_b = control_in.imm_sel ? imm5 : sr2;
	assign addr_sum  = sr1 + offset6;

	always_comb begin
		case (control_in.aluop)
			alu_add:  result = sr1 + operand_b;
			alu_and:  result = sr1 & operand_b;
			alu_not:  result = ~sr1;
			alu_pass: result = addr_sum;
			default:  result = sr1 + operand_b;
		endcase
		// bubbles carry their fetch address down the pipe.
		if (control_in.opcode == op_nop) begin
			result = pc_in;
		end
	end

	// EX/MEM register.
	always_ff @(posedge clk) begin
		if (reset) begin
			ir      <= 16'h0000;
			control <= ctrl_nop;
		end else begin
			ir      <= ir_in;
			control <= control_in;
		end
		alu        <= result;
		store_data <= sr2;
	end

endmodule : execution_module

// ==== source/instruction_decode.sv ====
`timescale 1ns/10ps

module instruction_decode (
	input  logic                    clk,
	input  logic                    reset,
	input  lc3b_types::lc3b_word    ir_in,
	input  lc3b_types::lc3b_word    pc_in,
	input  logic                    wb_load,
	input  lc3b_types::lc3b_reg     wb_dest,
	input  lc3b_types::lc3b_word    wb_data,
	output lc3b_types::lc3b_word    ir,
	output lc3b_types::lc3b_word    pc,
	output lc3b_types::lc3b_control control,
	output lc3b_types::lc3b_word    sr1,
	output lc3b_types::lc3b_word    sr2
);
	import lc3b_types::*;

	lc3b_word    regfile [8];
	lc3b_control ctrl_next;
	lc3b_reg     sr1_idx;
	lc3b_reg     sr2_idx;
	lc3b_word    sr1_data;
	lc3b_word    sr2_data;

	// ==============================
	// control word
	// ==============================

	always_comb begin
		ctrl_next = ctrl_nop;
		case (ir_in[15:12])
			op_add: begin
				ctrl_next.opcode       = op_add;
				ctrl_next.aluop        = alu_add;
				ctrl_next.imm_sel      = ir_in[5];
				ctrl_next.regfile_load = 1'b1;
			end
			op_and: begin
				ctrl_next.opcode       = op_and;
				ctrl_next.aluop        = alu_and;
				ctrl_next.imm_sel      = ir_in[5];
				ctrl_next.regfile_load = 1'b1;
			end
			op_not: begin
				ctrl_next.opcode       = op_not;
				ctrl_next.aluop        = alu_not;
				ctrl_next.regfile_load = 1'b1;
			end
			op_ldr: begin
				ctrl_next.opcode       = op_ldr;
				ctrl_next.aluop        = alu_pass;
				ctrl_next.regfile_load = 1'b1;
			end
			op_str: begin
				ctrl_next.opcode = op_str;
				ctrl_next.aluop  = alu_pass;
			end
			// anything else runs as a bubble.
			default: begin
				ctrl_next = ctrl_nop;
			end
		endcase
	end

	// ==============================
	// register file
	// ==============================

	// store data comes from the DR field.
	assign sr1_idx = ir_in[8:6];
	assign sr2_idx = (ir_in[15:12] == op_str) ? ir_in[11:9] : ir_in[2:0];

	// write-through, same-cycle writeback wins.
	assign sr1_data = (wb_load && (wb_dest == sr1_idx)) ? wb_data : regfile[sr1_idx];
	assign sr2_data = (wb_load && (wb_dest == sr2_idx)) ? wb_data : regfile[sr2_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regfile[i] <= 16'h0000;
			end
		end else if (wb_load) begin
			regfile[wb_dest] <= wb_data;
		end
	end

	// ID/EX register.
	always_ff @(posedge clk) begin
		if (reset) begin
			ir      <= 16'h0000;
			control <= ctrl_nop;
		end else begin
			ir      <= ir_in;
			control <= ctrl_next;
		end
		pc  <= pc_in;
		sr1 <= sr1_data;
		sr2 <= sr2_data;
	end

endmodule : instruction_decode

// ==== source/instruction_fetch.sv ====
`timescale 1ns/10ps

module instruction_fetch (
	input  logic                 clk,
	input  logic                 reset,
	input  lc3b_types::lc3b_word instr,
	output lc3b_types::lc3b_word pc,
	output lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_word ir_pc
);

	// ==============================
	// program counter
	// ==============================

	// one word per cycle, nothing redirects it.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 16'h0000;
		end else begin
			pc <= pc + 16'd2;
		end
	end

	// ==============================
	// IF/ID register
	// ==============================

	// all-zero word is a no-op.
	always_ff @(posedge clk) begin
		if (reset) begin
			ir    <= 16'h0000;
			ir_pc <= 16'h0000;
		end else begin
			ir    <= instr;
			ir_pc <= pc;
		end
	end

endmodule : instruction_fetch

// ==== source/lc3b_types.sv ====
package lc3b_types;

// ==============================
// basic word types
// ==============================

// data, addresses and instructions.
typedef logic [15:0] lc3b_word;

// register index, eight registers.
typedef logic [2:0] lc3b_reg;

// ==============================
// encodings
// ==============================

// opcode field ir[15:12]; only the supported subset.
typedef enum logic [3:0] {
	op_nop = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

// execute stage operation.
// alu_pass forwards the address adder for loads and stores.
typedef enum logic [1:0] {
	alu_add  = 2'b00,
	alu_and  = 2'b01,
	alu_not  = 2'b10,
	alu_pass = 2'b11
} lc3b_aluop;

// ==============================
// control word
// ==============================

// travels with the instruction through every stage.
typedef struct packed {
	lc3b_opcode opcode;
	lc3b_aluop  aluop;
	logic       imm_sel;
	logic       regfile_load;
} lc3b_control;

// bubble / reset value.
localparam lc3b_control ctrl_nop = '{
	opcode:       op_nop,
	aluop:        alu_add,
	imm_sel:      1'b0,
	regfile_load: 1'b0
};

endpackage : lc3b_types

// ==== source/memory_module.sv ====
`timescale 1ns/10ps

module memory_module (
	input  logic                    clk,
	input  logic                    reset,
	input  lc3b_types::lc3b_word    ir_in,
	input  lc3b_types::lc3b_control control_in,
	input  lc3b_types::lc3b_word    alu_in,
	input  lc3b_types::lc3b_word    store_data,
	input  lc3b_types::lc3b_word    mem_rdata,
	output lc3b_types::lc3b_word    mem_addr,
	output logic                    mem_read,
	output logic                    mem_write,
	output lc3b_types::lc3b_word    mem_wdata,
	output lc3b_types::lc3b_word    ir,
	output lc3b_types::lc3b_control control,
	output lc3b_types::lc3b_word    alu,
	output lc3b_types::lc3b_word    mdr
);
	import lc3b_types::*;

	// address comes straight from the address adder.
	assign mem_addr  = alu_in;
	assign mem_read  = (control_in.opcode == op_ldr);
	assign mem_write = (control_in.opcode == op_str);
	assign mem_wdata = store_data;

	// MEM/WB register.
	always_ff @(posedge clk) begin
		if (reset) begin
			ir      <= 16'h0000;
			control <= ctrl_nop;
		end else begin
			ir      <= ir_in;
			control <= control_in;
		end
		alu <= alu_in;
		mdr <= mem_rdata;
	end

endmodule : memory_module

// ==== source/writeback_module.sv ====
`timescale 1ns/10ps

module writeback_module (
	input  lc3b_types::lc3b_word    ir_in,
	input  lc3b_types::lc3b_control control_in,
	input  lc3b_types::lc3b_word    alu_in,
	input  lc3b_types::lc3b_word    mdr_in,
	output logic                    regfile_load,
	output lc3b_types::lc3b_reg     dest,
	output lc3b_types::lc3b_word    data
);
	import lc3b_types::*;

	// ==============================
	// result select
	// ==============================

	// loads return memory data, everything else the ALU.
	assign data = (control_in.opcode == op_ldr) ? mdr_in : alu_in;

	// DR is bits 11:9 for every writing instruction.
	assign dest = ir_in[11:9];

	assign regfile_load = control_in.regfile_load;

endmodule : writeback_module
